// ==== rtl/ecc_defs.svh ====
// ECC memory controller width and depth definitions
// Shared by the package and every RTL block of the controller

`ifndef ECC_DEFS_SVH
`define ECC_DEFS_SVH

// ====================
// Word layout
// ====================

// Data word carried by each request
`define ECC_DATA_W  64
// Seven Hamming bits plus the overall parity bit
`define ECC_CHECK_W 8
// Stored codeword, data plus check bits
`define ECC_CODE_W  72

// ====================
// Array and log sizes
// ====================

// Word address into the array
`define ECC_ADDR_W  8
// Words held in the array
`define ECC_DEPTH   256
// Saturating error counter
`define ECC_CNT_W   16

`endif

// ==== rtl/ecc_pkg.sv ====
// ECC memory controller package
// Opcode and status enums, pipeline structs and the Hamming(72,64)
// encode and syndrome functions

`include "ecc_defs.svh"

package ecc_pkg;

    // ====================
    // Enums
    // ====================

    // Command opcode from the encoder to the store
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2
    } mem_op_e;

    // Outcome of a read check
    typedef enum logic [1:0] {
        ST_OK            = 2'd0,
        ST_CORRECTED     = 2'd1,
        ST_UNCORRECTABLE = 2'd2
    } ecc_status_e;

    // ====================
    // Pipeline structs
    // ====================

    // Encoder to store, 82 bits
    typedef struct packed {
        mem_op_e                 op;
        logic [`ECC_ADDR_W-1:0]  addr;
        logic [`ECC_CODE_W-1:0]  codeword;
    } mem_cmd_t;

    // Store to checker, 81 bits
    typedef struct packed {
        logic                    valid;
        logic [`ECC_ADDR_W-1:0]  addr;
        logic [`ECC_CODE_W-1:0]  codeword;
    } mem_rd_t;

    // Checker to log and top, 75 bits
    typedef struct packed {
        logic                    valid;
        logic [`ECC_ADDR_W-1:0]  addr;
        logic [`ECC_DATA_W-1:0]  data;
        ecc_status_e             status;
    } ecc_rsp_t;

    // ====================
    // Code functions
    // ====================

    // Position parity, bit p is the XOR of every position with index bit p set
    // Zero on a clean codeword, the error position on a single flip
    function automatic logic [`ECC_CHECK_W-2:0] ecc_pos_parity(
        input logic [`ECC_CODE_W-1:0] cw
    );
        logic [`ECC_CHECK_W-2:0] par;
        par = '0;
        for (int p = 0; p < `ECC_CHECK_W - 1; p++) begin
            for (int i = 1; i < `ECC_CODE_W; i++) begin
                if (((i >> p) & 1) == 1) begin
                    par[p] = par[p] ^ cw[i];
                end
            end
        end
        return par;
    endfunction

    // Data into non-power-of-two slots, data bit 0 at position 3
    // Check bits at 1, 2, 4 .. 64, overall parity at bit 0
    function automatic logic [`ECC_CODE_W-1:0] ecc_encode(
        input logic [`ECC_DATA_W-1:0] data
    );
        logic [`ECC_CODE_W-1:0]  cw;
        logic [`ECC_CHECK_W-2:0] chk;
        int                      k;
        cw = '0;
        k  = 0;
        for (int i = 1; i < `ECC_CODE_W; i++) begin
            // Power-of-two slots stay zero for now
            if ((i & (i - 1)) != 0) begin
                cw[i] = data[k];
                k++;
            end
        end
        // Check slots are still zero, so position parity gives the check values
        chk = ecc_pos_parity(cw);
        for (int p = 0; p < `ECC_CHECK_W - 1; p++) begin
            cw[1 << p] = chk[p];
        end
        // Even parity over the whole word
        cw[0] = ^cw[`ECC_CODE_W-1:1];
        return cw;
    endfunction

    // Returns {syndrome[6:0], parity_odd}
    function automatic logic [`ECC_CHECK_W-1:0] ecc_syndrome(
        input logic [`ECC_CODE_W-1:0] cw
    );
        return {ecc_pos_parity(cw), ^cw};
    endfunction

endpackage

// ==== rtl/ecc_write_encoder.sv ====
// ECC write encoder
// Registers each request as a store command, encoding write data into a
// SECDED codeword and applying the fault-injection mask

`include "ecc_defs.svh"

module ecc_write_encoder (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    req_valid_i,
    input  logic                    req_write_i,
    input  logic [`ECC_ADDR_W-1:0]  req_addr_i,
    input  logic [`ECC_DATA_W-1:0]  req_wdata_i,
    input  logic [`ECC_CODE_W-1:0]  inj_mask_i,
    output ecc_pkg::mem_cmd_t       cmd_o
);

    ecc_pkg::mem_op_e          op_q;
    logic [`ECC_ADDR_W-1:0]    addr_q;
    logic [`ECC_CODE_W-1:0]    code_q;

    // ====================
    // Opcode register
    // ====================

    // One command per strobe, idle otherwise
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            op_q <= ecc_pkg::OP_IDLE;
        end else if (req_valid_i) begin
            op_q <= req_write_i ? ecc_pkg::OP_WRITE : ecc_pkg::OP_READ;
        end else begin
            op_q <= ecc_pkg::OP_IDLE;
        end
    end

    // ====================
    // Payload register
    // ====================

    // Mask flips stored bits on purpose, zero mask gives a clean word
    // Reads carry no codeword
    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            addr_q <= req_addr_i;
            if (req_write_i) begin
                code_q <= ecc_pkg::ecc_encode(req_wdata_i) ^ inj_mask_i;
            end else begin
                code_q <= '0;
            end
        end
    end

    assign cmd_o = '{op: op_q, addr: addr_q, codeword: code_q};

    // Every sampled strobe turns into a command on the next cycle
    a_strobe_to_cmd: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i |=> (cmd_o.op != ecc_pkg::OP_IDLE)
    );

endmodule

// ==== rtl/ecc_store.sv ====
// ECC codeword store
// Single-port array of codewords with a registered read port that
// carries the address along with the read data

`include "ecc_defs.svh"

module ecc_store (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  ecc_pkg::mem_cmd_t  cmd_i,
    output ecc_pkg::mem_rd_t   rd_o
);

    logic [`ECC_CODE_W-1:0]  mem_q [`ECC_DEPTH];
    logic                    rd_valid_q;
    logic [`ECC_ADDR_W-1:0]  rd_addr_q;
    logic [`ECC_CODE_W-1:0]  rd_code_q;

    // ====================
    // Array access
    // ====================

    // Write lands at the edge, so a read one cycle later sees it
    always_ff @(posedge clk_i) begin
        if (cmd_i.op == ecc_pkg::OP_WRITE) begin
            mem_q[cmd_i.addr] <= cmd_i.codeword;
        end
        if (cmd_i.op == ecc_pkg::OP_READ) begin
            rd_addr_q <= cmd_i.addr;
            rd_code_q <= mem_q[cmd_i.addr];
        end
    end

    // Read valid, one pulse per read command
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= (cmd_i.op == ecc_pkg::OP_READ);
        end
    end

    assign rd_o = '{valid: rd_valid_q, addr: rd_addr_q, codeword: rd_code_q};

    // Encoder addresses stay inside the array
    a_addr_in_range: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (cmd_i.op != ecc_pkg::OP_IDLE) |-> (int'(cmd_i.addr) < `ECC_DEPTH)
    );

endmodule

// ==== rtl/ecc_read_checker.sv ====
// ECC read checker
// Computes the syndrome of each read codeword, corrects single-bit errors,
// flags double-bit errors and registers the response

`include "ecc_defs.svh"

module ecc_read_checker (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  ecc_pkg::mem_rd_t   rd_i,
    output ecc_pkg::ecc_rsp_t  rsp_o
);

    logic [`ECC_CHECK_W-2:0]  syndrome;
    logic                     parity_odd;
    logic [`ECC_CODE_W-1:0]   fix_mask;
    logic [`ECC_CODE_W-1:0]   fixed_code;
    logic [`ECC_DATA_W-1:0]   data_d;
    ecc_pkg::ecc_status_e     status_d;

    logic                     rsp_valid_q;
    logic [`ECC_ADDR_W-1:0]   rsp_addr_q;
    logic [`ECC_DATA_W-1:0]   rsp_data_q;
    ecc_pkg::ecc_status_e     rsp_status_q;

    // Pull data back out of the non-power-of-two slots
    function automatic logic [`ECC_DATA_W-1:0] extract_data(
        input logic [`ECC_CODE_W-1:0] cw
    );
        logic [`ECC_DATA_W-1:0] d;
        int                     k;
        d = '0;
        k = 0;
        for (int i = 1; i < `ECC_CODE_W; i++) begin
            if ((i & (i - 1)) != 0) begin
                d[k] = cw[i];
                k++;
            end
        end
        return d;
    endfunction

    // ====================
    // Syndrome and decode
    // ====================

    assign {syndrome, parity_odd} = ecc_pkg::ecc_syndrome(rd_i.codeword);

    // Odd parity means one flip, located by the syndrome
    // Syndrome zero with odd parity is the parity bit itself
    always_comb begin
        fix_mask = '0;
        status_d = ecc_pkg::ST_OK;
        if (parity_odd) begin
            if (int'(syndrome) < `ECC_CODE_W) begin
                fix_mask[syndrome] = 1'b1;
                status_d = ecc_pkg::ST_CORRECTED;
            end else begin
                // Points past the word, more than one flip
                status_d = ecc_pkg::ST_UNCORRECTABLE;
            end
        end else if (syndrome != '0) begin
            // Even parity but nonzero syndrome, double error
            status_d = ecc_pkg::ST_UNCORRECTABLE;
        end
    end

    assign fixed_code = rd_i.codeword ^ fix_mask;
    assign data_d     = extract_data(fixed_code);

    // ====================
    // Response register
    // ====================

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rd_i.valid;
        end
    end

    // Payload held until the next read
    always_ff @(posedge clk_i) begin
        if (rd_i.valid) begin
            rsp_addr_q   <= rd_i.addr;
            rsp_data_q   <= data_d;
            rsp_status_q <= status_d;
        end
    end

    assign rsp_o = '{valid:  rsp_valid_q,
                     addr:   rsp_addr_q,
                     data:   rsp_data_q,
                     status: rsp_status_q};

    // A word with odd parity is never reported as clean
    a_odd_not_ok: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (rd_i.valid && (^rd_i.codeword)) |=> (rsp_o.status != ecc_pkg::ST_OK)
    );

endmodule

// ==== rtl/ecc_error_log.sv ====
// ECC error log
// Counts non-OK read responses with saturation and keeps the address
// of the most recent one

`include "ecc_defs.svh"

module ecc_error_log (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  ecc_pkg::ecc_rsp_t       rsp_i,
    output logic                    err_o,
    output logic [`ECC_CNT_W-1:0]   err_count_o,
    output logic [`ECC_ADDR_W-1:0]  err_addr_o
);

    logic  rsp_err;

    // Corrected and uncorrectable both count
    assign rsp_err = rsp_i.valid && (rsp_i.status != ecc_pkg::ST_OK);

    // ====================
    // Log registers
    // ====================

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_o       <= 1'b0;
            err_count_o <= '0;
            err_addr_o  <= '0;
        end else begin
            // One-cycle pulse per erroneous response
            err_o <= rsp_err;
            if (rsp_err) begin
                err_addr_o <= rsp_i.addr;
                // Stick at all ones
                if (err_count_o != {`ECC_CNT_W{1'b1}}) begin
                    err_count_o <= err_count_o + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/ecc_mem_ctrl.sv ====
// SECDED memory controller top level
// Encoder, codeword store, read checker and error log in a fixed
// three-cycle read pipeline

`include "ecc_defs.svh"

module ecc_mem_ctrl (
    // ====================
    // Clock and reset
    // ====================
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    // ====================
    // Request side
    // ====================
    input  logic                    req_valid_i,
    input  logic                    req_write_i,
    input  logic [`ECC_ADDR_W-1:0]  req_addr_i,
    input  logic [`ECC_DATA_W-1:0]  req_wdata_i,
    // XORed into the stored codeword on writes
    input  logic [`ECC_CODE_W-1:0]  inj_mask_i,

    // ====================
    // Read response
    // ====================
    output logic                    rsp_valid_o,
    output logic [`ECC_DATA_W-1:0]  rsp_data_o,
    output ecc_pkg::ecc_status_e    rsp_status_o,

    // ====================
    // Error log
    // ====================
    output logic                    err_o,
    output logic [`ECC_CNT_W-1:0]   err_count_o,
    output logic [`ECC_ADDR_W-1:0]  err_addr_o
);

    ecc_pkg::mem_cmd_t   cmd;
    ecc_pkg::mem_rd_t    rd;
    ecc_pkg::ecc_rsp_t   rsp;

    // Request to store command
    ecc_write_encoder u_encoder (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_write_i (req_write_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .inj_mask_i  (inj_mask_i),
        .cmd_o       (cmd)
    );

    // Codeword array
    ecc_store u_store (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .cmd_i   (cmd),
        .rd_o    (rd)
    );

    // Check and correct
    ecc_read_checker u_checker (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .rd_i    (rd),
        .rsp_o   (rsp)
    );

    // Error bookkeeping, one cycle behind the response
    ecc_error_log u_log (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rsp_i       (rsp),
        .err_o       (err_o),
        .err_count_o (err_count_o),
        .err_addr_o  (err_addr_o)
    );

    assign rsp_valid_o  = rsp.valid;
    assign rsp_data_o   = rsp.data;
    assign rsp_status_o = rsp.status;

endmodule

// ==== tests/tb_clk_gen.sv ====
// Testbench clock and reset source
// 100 ns clock, active-low reset held for the first 8 cycles

module tb_clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // Free-running clock, first rising edge at half a period
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release a quarter period after a rising edge, clear of both edges
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #(PERIOD_NS / 4) rst_n_o = 1'b1;
    end

endmodule

// ==== tests/tb_ecc_mem_ctrl.sv ====
// Testbench for the SECDED memory controller
// Table of writes and reads with fault injection, checked against a
// popcount reference and a shadow copy of the written data

`include "ecc_defs.svh"

module tb_ecc_mem_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    // One table row per request, data and status are the expected values on reads
    typedef struct packed {
        logic                    wr;
        logic [`ECC_ADDR_W-1:0]  addr;
        logic [`ECC_DATA_W-1:0]  data;
        logic [`ECC_CODE_W-1:0]  mask;
        ecc_pkg::ecc_status_e    status;
    } req_entry_t;

    logic                    clk;
    logic                    rst_n;
    logic                    req_valid;
    logic                    req_write;
    logic [`ECC_ADDR_W-1:0]  req_addr;
    logic [`ECC_DATA_W-1:0]  req_wdata;
    logic [`ECC_CODE_W-1:0]  inj_mask;
    logic                    rsp_valid;
    logic [`ECC_DATA_W-1:0]  rsp_data;
    ecc_pkg::ecc_status_e    rsp_status;
    logic                    err;
    logic [`ECC_CNT_W-1:0]   err_count;
    logic [`ECC_ADDR_W-1:0]  err_addr;

    req_entry_t              stim[$];
    logic [`ECC_DATA_W-1:0]  shadow_data [`ECC_DEPTH];
    logic [`ECC_CODE_W-1:0]  shadow_mask [`ECC_DEPTH];
    logic [31:0]             rng_state = 32'd87592;
    logic                    stim_ready = 1'b0;
    // Error log model
    logic [`ECC_CNT_W-1:0]   exp_cnt = '0;
    logic [`ECC_ADDR_W-1:0]  exp_addr = '0;

    tb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    ecc_mem_ctrl u_ecc_mem_ctrl (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .req_valid_i  (req_valid),
        .req_write_i  (req_write),
        .req_addr_i   (req_addr),
        .req_wdata_i  (req_wdata),
        .inj_mask_i   (inj_mask),
        .rsp_valid_o  (rsp_valid),
        .rsp_data_o   (rsp_data),
        .rsp_status_o (rsp_status),
        .err_o        (err),
        .err_count_o  (err_count),
        .err_addr_o   (err_addr)
    );

    // ====================
    // Reference rules
    // ====================

    // xorshift32 step
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [`ECC_DATA_W-1:0] rand_data();
        return {next_rand(), next_rand()};
    endfunction

    // Flip count decides the outcome, one is fixed, two are only detected
    function automatic ecc_pkg::ecc_status_e status_for_mask(
        input logic [`ECC_CODE_W-1:0] m
    );
        int ones;
        ones = 0;
        for (int i = 0; i < `ECC_CODE_W; i++) begin
            ones += int'(m[i]);
        end
        case (ones)
            0:       return ecc_pkg::ST_OK;
            1:       return ecc_pkg::ST_CORRECTED;
            default: return ecc_pkg::ST_UNCORRECTABLE;
        endcase
    endfunction

    function automatic logic [`ECC_CODE_W-1:0] one_hot(input int pos);
        return `ECC_CODE_W'(1) << pos;
    endfunction

    // ====================
    // Stimulus table
    // ====================

    task automatic add_write(
        input logic [`ECC_ADDR_W-1:0] addr,
        input logic [`ECC_DATA_W-1:0] data,
        input logic [`ECC_CODE_W-1:0] mask
    );
        stim.push_back('{wr: 1'b1, addr: addr, data: data, mask: mask,
                         status: ecc_pkg::ST_OK});
        shadow_data[addr] = data;
        shadow_mask[addr] = mask;
    endtask

    // Expected values come from the last write to the address
    task automatic add_read(input logic [`ECC_ADDR_W-1:0] addr);
        stim.push_back('{wr: 1'b0, addr: addr, data: shadow_data[addr], mask: '0,
                         status: status_for_mask(shadow_mask[addr])});
    endtask

    task automatic build_stimulus();
        int p1;
        int p2;
        // Clean words, then back-to-back reads
        for (int i = 0; i < 32; i++) begin
            add_write(`ECC_ADDR_W'(i), rand_data(), '0);
        end
        for (int i = 0; i < 32; i++) begin
            add_read(`ECC_ADDR_W'(i));
        end
        // One flip at every codeword position, read right after the write
        for (int pos = 0; pos < `ECC_CODE_W; pos++) begin
            add_write(`ECC_ADDR_W'(100 + pos), rand_data(), one_hot(pos));
            add_read(`ECC_ADDR_W'(100 + pos));
        end
        // Two distinct flips
        for (int i = 0; i < 16; i++) begin
            p1 = int'(next_rand() % 32'd72);
            p2 = int'(next_rand() % 32'd71);
            if (p2 >= p1) begin
                p2++;
            end
            add_write(`ECC_ADDR_W'(200 + i), rand_data(), one_hot(p1) | one_hot(p2));
            add_read(`ECC_ADDR_W'(200 + i));
        end
        // Overwrite a clean word, newest data must come back
        add_write(`ECC_ADDR_W'(5), rand_data(), '0);
        add_read(`ECC_ADDR_W'(5));
        add_read(`ECC_ADDR_W'(6));
        add_read(`ECC_ADDR_W'(5));
    endtask

    // ====================
    // Checks
    // ====================

    task automatic check_value(
        input string                  name,
        input logic [`ECC_CODE_W-1:0] got,
        input logic [`ECC_CODE_W-1:0] exp
    );
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic check_reset_values();
        check_value("rsp_valid_o", `ECC_CODE_W'(rsp_valid), '0);
        check_value("err_o", `ECC_CODE_W'(err), '0);
        check_value("err_count_o", `ECC_CODE_W'(err_count), '0);
        check_value("err_addr_o", `ECC_CODE_W'(err_addr), '0);
    endtask

    // Response due 3 steps after its read, log update 4 steps after
    task automatic check_outputs(input int s);
        req_entry_t r;
        logic       exp_valid;
        logic       exp_err;
        exp_valid = 1'b0;
        exp_err   = 1'b0;
        if (s >= 3 && s - 3 < stim.size()) begin
            exp_valid = !stim[s - 3].wr;
        end
        check_value("rsp_valid_o", `ECC_CODE_W'(rsp_valid), `ECC_CODE_W'(exp_valid));
        if (exp_valid) begin
            r = stim[s - 3];
            check_value("rsp_status_o", `ECC_CODE_W'(rsp_status), `ECC_CODE_W'(r.status));
            if (r.status != ecc_pkg::ST_UNCORRECTABLE) begin
                check_value("rsp_data_o", `ECC_CODE_W'(rsp_data), `ECC_CODE_W'(r.data));
            end
        end
        if (s >= 4 && s - 4 < stim.size()) begin
            r = stim[s - 4];
            if (!r.wr && r.status != ecc_pkg::ST_OK) begin
                exp_err  = 1'b1;
                exp_addr = r.addr;
                if (exp_cnt != '1) begin
                    exp_cnt = exp_cnt + `ECC_CNT_W'(1);
                end
            end
        end
        check_value("err_o", `ECC_CODE_W'(err), `ECC_CODE_W'(exp_err));
        check_value("err_count_o", `ECC_CODE_W'(err_count), `ECC_CODE_W'(exp_cnt));
        check_value("err_addr_o", `ECC_CODE_W'(err_addr), `ECC_CODE_W'(exp_addr));
    endtask

    task automatic drive_entry(input int s);
        if (s < stim.size()) begin
            req_valid = 1'b1;
            req_write = stim[s].wr;
            req_addr  = stim[s].addr;
            req_wdata = stim[s].wr ? stim[s].data : '0;
            inj_mask  = stim[s].mask;
        end else begin
            req_valid = 1'b0;
            req_write = 1'b0;
            inj_mask  = '0;
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        inj_mask  = '0;
        build_stimulus();
        stim_ready = 1'b1;
        // Idle outputs through reset and the first cycle after it
        do begin
            @(negedge clk);
            check_reset_values();
        end while (!rst_n);
        // Check first, then drive, all on the falling edge
        for (int s = 0; s < stim.size() + 5; s++) begin
            @(negedge clk);
            check_outputs(s);
            drive_entry(s);
        end
        $display("Simulation PASSED");
        $finish;
    end

    // Watchdog, six cycles per table row plus margin
    initial begin
        wait (stim_ready);
        repeat (stim.size() * 6 + 100) @(posedge clk);
        $display("Timeout: the test did not finish within %0d clock cycles",
                 stim.size() * 6 + 100);
        $display("Simulation FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/ecc_pkg.sv
rtl/ecc_write_encoder.sv
rtl/ecc_store.sv
rtl/ecc_read_checker.sv
rtl/ecc_error_log.sv
rtl/ecc_mem_ctrl.sv
tests/tb_clk_gen.sv
tests/tb_ecc_mem_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ECC memory controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ecc_mem_ctrl -f vlog.f

# A failed check exits nonzero, the captured output still decides the result
sim_out=$(./obj_dir/Vtb_ecc_mem_ctrl 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Simulation PASSED"; then
    exit 0
else
    exit 1
fi
